// ==== hw/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

  ////////////////////////////////////////////////////////////
  // Address and data geometry.
  ////////////////////////////////////////////////////////////
  localparam int ADDR_W      = 16; // Byte address width of the processor.
  localparam int WORD_W      = 16; // One data word is two bytes.
  localparam int BLOCK_WORDS = 8;  // A cache block holds eight words.
  localparam int OFFSET_W    = 4;  // Byte offset inside a 16-byte block.

  typedef logic [ADDR_W-1:0]            addr_t;     // Byte address.
  typedef logic [WORD_W-1:0]            word_t;     // Data word.
  typedef logic [OFFSET_W-2:0]          word_idx_t; // Word within a block, address bits 3 to 1.
  typedef logic [$clog2(BLOCK_WORDS):0] fill_cnt_t; // Counts filled words from 0 up to 8.

  ////////////////////////////////////////////////////////////
  // State encodings.
  ////////////////////////////////////////////////////////////
  typedef enum logic {
    FILL_IDLE, // Waiting for a miss.
    FILL_WAIT  // Fetching the block from memory.
  } fill_state_e;

  typedef enum logic [1:0] {
    ACC_IDLE,   // No CPU request in progress.
    ACC_LOOKUP, // Tag compare on the captured address.
    ACC_MISS,   // Block is being filled.
    ACC_ACK     // Word returned, waiting for req to drop.
  } access_state_e;

endpackage

`default_nettype wire

// ==== hw/cache_fill_if.sv ====
`default_nettype none

// Write path from the line-fill machine into both arrays.
interface cache_fill_if;

  logic             data_we; // Write one word into the data array.
  logic             tag_we;  // Write the tag and set the valid bit.
  cache_pkg::addr_t wr_addr; // Tag and index pick the set, bits 3 to 1 pick the word.
  cache_pkg::word_t wr_data; // Word returned by memory.

  modport ctrl (
    output data_we,
    output tag_we,
    output wr_addr,
    output wr_data
  );

  modport array (
    input data_we,
    input tag_we,
    input wr_addr,
    input wr_data
  );

endinterface

`default_nettype wire

// ==== hw/cache_fill_ctrl.sv ====
`default_nettype none

module cache_fill_ctrl (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             miss_detected,  // One-cycle miss pulse from the access machine.
  input  cache_pkg::addr_t miss_addr,      // Address that missed.
  input  cache_pkg::word_t mem_data,       // Word returned by memory.
  input  logic             mem_data_valid, // One-cycle strobe for mem_data.
  output logic             fill_busy,      // High while a fill is in progress.
  output logic             mem_rd,         // Memory read request.
  output cache_pkg::addr_t mem_addr,       // Word address being fetched.
  cache_fill_if.ctrl       fill
);

  localparam int WORD_BYTES_I = cache_pkg::WORD_W / 8; // Bytes per word.
  localparam cache_pkg::addr_t WORD_BYTES  = cache_pkg::addr_t'(WORD_BYTES_I);
  localparam cache_pkg::addr_t BLOCK_BYTES =
    cache_pkg::addr_t'(cache_pkg::BLOCK_WORDS * WORD_BYTES_I);
  localparam cache_pkg::fill_cnt_t LAST_CNT = cache_pkg::fill_cnt_t'(cache_pkg::BLOCK_WORDS);

  cache_pkg::fill_state_e state;     // Current fill state.
  cache_pkg::fill_state_e nxt_state; // Next fill state.
  cache_pkg::fill_cnt_t   word_cnt;  // Words written so far.
  cache_pkg::addr_t       base_addr; // Block-aligned miss address.
  logic                   clr_cnt;   // Start a new fill.
  logic                   incr_cnt;  // One more word has arrived.
  logic                   chunks_filled; // All eight words are in the data array.

  assign base_addr = {miss_addr[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W],
                      {cache_pkg::OFFSET_W{1'b0}}}; // Clear the byte offset.
  assign chunks_filled = (word_cnt == LAST_CNT); // Count has reached a full block.

  ////////////////////////////////////////////////////////////
  // Word count, memory address and state registers.
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= cache_pkg::FILL_IDLE; // Come out of reset idle.
      word_cnt <= '0;                   // No words filled.
      mem_addr <= '0;                   // Address is don't-care until a miss.
    end else begin
      state <= nxt_state; // Advance the machine.
      if (clr_cnt) begin
        word_cnt <= '0;        // Restart the count for the new block.
        mem_addr <= base_addr; // First word of the block.
      end else if (incr_cnt) begin
        word_cnt <= word_cnt + cache_pkg::fill_cnt_t'(1); // One more word in.
        mem_addr <= mem_addr + WORD_BYTES;                // Step to the next word.
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Next state and outputs.
  ////////////////////////////////////////////////////////////
  always_comb begin
    nxt_state    = state; // Hold by default.
    clr_cnt      = 1'b0;  // No restart unless a miss arrives.
    incr_cnt     = 1'b0;  // No word unless memory returns one.
    fill_busy    = 1'b0;  // Idle unless filling.
    mem_rd       = 1'b0;  // No memory read unless filling.
    fill.data_we = 1'b0;  // No data write by default.
    fill.tag_we  = 1'b0;  // No tag write by default.

    case (state)
      cache_pkg::FILL_IDLE: begin
        if (miss_detected) begin
          clr_cnt   = 1'b1;                 // Load the block base.
          fill_busy = 1'b1;                 // Busy from the miss cycle on.
          nxt_state = cache_pkg::FILL_WAIT; // Start fetching.
        end
      end

      cache_pkg::FILL_WAIT: begin
        if (chunks_filled) begin
          fill.tag_we = 1'b1;                 // Block complete, mark it valid.
          nxt_state   = cache_pkg::FILL_IDLE; // Let the lookup retry.
        end else begin
          fill_busy    = 1'b1;           // Stall the access machine.
          mem_rd       = 1'b1;           // Keep asking for the current word.
          fill.data_we = mem_data_valid; // Write each word as it arrives.
          incr_cnt     = mem_data_valid; // And count it.
        end
      end

      default: nxt_state = cache_pkg::FILL_IDLE; // Recover from an illegal state.
    endcase
  end

  assign fill.wr_data = mem_data; // Memory word goes straight into the array.
  // After the last word the address has run one block past the base, so step it back
  // for the tag write.
  assign fill.wr_addr = chunks_filled ? (mem_addr - BLOCK_BYTES) : mem_addr;

endmodule

`default_nettype wire

// ==== hw/cache_tag_array.sv ====
`default_nettype none

module cache_tag_array #(
  parameter int SET_BITS = 4 // Index bits, 1 to 8.
) (
  input  logic             clk,
  input  logic             arst_n,
  input  cache_pkg::addr_t lookup_addr, // Address being looked up.
  output logic             hit,         // Valid tag match for lookup_addr.
  cache_fill_if.array      fill
);

  localparam int NUM_SETS = 1 << SET_BITS;                                   // Sets in the cache.
  localparam int TAG_W    = cache_pkg::ADDR_W - cache_pkg::OFFSET_W - SET_BITS; // Tag bits.

  typedef logic [TAG_W-1:0]    tag_t; // Stored tag.
  typedef logic [SET_BITS-1:0] set_t; // Set index.

  tag_t                tag_mem [NUM_SETS]; // One tag per set.
  logic [NUM_SETS-1:0] valid;              // One valid bit per set.
  set_t                wr_set;             // Set written by the fill.
  tag_t                wr_tag;             // Tag written by the fill.
  set_t                rd_set;             // Set picked by the lookup.
  tag_t                rd_tag;             // Tag of the lookup address.

  ////////////////////////////////////////////////////////////
  // Address fields.
  ////////////////////////////////////////////////////////////
  assign wr_set = fill.wr_addr[cache_pkg::OFFSET_W +: SET_BITS];   // Index of the filled block.
  assign wr_tag = fill.wr_addr[cache_pkg::ADDR_W-1 -: TAG_W];      // Tag of the filled block.
  assign rd_set = lookup_addr[cache_pkg::OFFSET_W +: SET_BITS];    // Index of the lookup.
  assign rd_tag = lookup_addr[cache_pkg::ADDR_W-1 -: TAG_W];       // Tag of the lookup.

  // Valid bits start cleared so nothing hits after reset.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid <= '0; // Empty cache.
    end else if (fill.tag_we) begin
      valid[wr_set] <= 1'b1; // Block is now present.
    end
  end

  always_ff @(posedge clk) begin
    if (fill.tag_we) begin
      tag_mem[wr_set] <= wr_tag; // Replace whatever block lived in this set.
    end
  end

  assign hit = valid[rd_set] && (tag_mem[rd_set] == rd_tag); // Direct-mapped compare.

endmodule

`default_nettype wire

// ==== hw/cache_data_array.sv ====
`default_nettype none

module cache_data_array #(
  parameter int SET_BITS = 4 // Index bits, 1 to 8.
) (
  input  logic             clk,
  input  cache_pkg::addr_t rd_addr, // Word address to read.
  output cache_pkg::word_t rd_data, // Word at rd_addr.
  cache_fill_if.array      fill
);

  localparam int NUM_SETS = 1 << SET_BITS;                   // Sets in the cache.
  localparam int DEPTH    = NUM_SETS * cache_pkg::BLOCK_WORDS; // Words in the cache.
  localparam int IDX_W    = SET_BITS + $bits(cache_pkg::word_idx_t); // Set and word bits.

  typedef logic [IDX_W-1:0] idx_t; // Flat word index, set above word.

  cache_pkg::word_t    data_mem [DEPTH]; // Word storage.
  cache_pkg::word_idx_t wr_word;         // Word within the filled block.
  cache_pkg::word_idx_t rd_word;         // Word within the looked-up block.
  idx_t                wr_idx;           // Flat write index.
  idx_t                rd_idx;           // Flat read index.

  assign wr_word = fill.wr_addr[cache_pkg::OFFSET_W-1:1]; // Drop the byte bit.
  assign rd_word = rd_addr[cache_pkg::OFFSET_W-1:1];      // Drop the byte bit.
  assign wr_idx  = {fill.wr_addr[cache_pkg::OFFSET_W +: SET_BITS], wr_word}; // Set then word.
  assign rd_idx  = {rd_addr[cache_pkg::OFFSET_W +: SET_BITS], rd_word};      // Set then word.

  always_ff @(posedge clk) begin
    if (fill.data_we) begin
      data_mem[wr_idx] <= fill.wr_data; // One word per memory return.
    end
  end

  assign rd_data = data_mem[rd_idx]; // Asynchronous read for the lookup cycle.

endmodule

`default_nettype wire

// ==== hw/cache_access_ctrl.sv ====
`default_nettype none

module cache_access_ctrl (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             cpu_req,       // Four-phase request from the CPU.
  input  cache_pkg::addr_t cpu_addr,      // Byte address, stable while cpu_req is high.
  output logic             cpu_ack,       // Four-phase acknowledge.
  output cache_pkg::word_t cpu_data,      // Word returned with cpu_ack.
  input  logic             hit,           // Tag compare result for lookup_addr.
  input  cache_pkg::word_t rd_data,       // Data array word at lookup_addr.
  output logic             miss_detected, // Starts a block fill.
  output cache_pkg::addr_t miss_addr,     // Address to fill from.
  input  logic             fill_busy,     // Fill still running.
  output cache_pkg::addr_t lookup_addr    // Address driven into both arrays.
);

  cache_pkg::access_state_e state;     // Current access state.
  cache_pkg::access_state_e nxt_state; // Next access state.
  cache_pkg::addr_t         addr_q;    // Request address held for the whole transfer.

  ////////////////////////////////////////////////////////////
  // State register and transitions.
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= cache_pkg::ACC_IDLE; // No transfer after reset.
    end else begin
      state <= nxt_state; // Advance the machine.
    end
  end

  always_comb begin
    nxt_state = state; // Hold by default.
    case (state)
      cache_pkg::ACC_IDLE: begin
        if (cpu_req) nxt_state = cache_pkg::ACC_LOOKUP; // New request, compare next cycle.
      end
      cache_pkg::ACC_LOOKUP: begin
        nxt_state = hit ? cache_pkg::ACC_ACK : cache_pkg::ACC_MISS; // Return or fill.
      end
      cache_pkg::ACC_MISS: begin
        if (!fill_busy) nxt_state = cache_pkg::ACC_LOOKUP; // Block is in, try again.
      end
      cache_pkg::ACC_ACK: begin
        if (!cpu_req) nxt_state = cache_pkg::ACC_IDLE; // CPU saw the ack, drop it.
      end
      default: nxt_state = cache_pkg::ACC_IDLE; // Recover from an illegal state.
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Address capture and returned word.
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if ((state == cache_pkg::ACC_IDLE) && cpu_req) begin
      addr_q <= cpu_addr; // Capture once at the start of the transfer.
    end
  end

  always_ff @(posedge clk) begin
    if ((state == cache_pkg::ACC_LOOKUP) && hit) begin
      cpu_data <= rd_data; // Word is held until the next hit.
    end
  end

  assign lookup_addr   = addr_q;                                   // Same address on every retry.
  assign miss_addr     = addr_q;                                   // Fill uses the block of addr_q.
  assign miss_detected = (state == cache_pkg::ACC_LOOKUP) && !hit; // One cycle per failed lookup.
  assign cpu_ack       = (state == cache_pkg::ACC_ACK);            // Decoded from the state flop.

endmodule

`default_nettype wire

// ==== hw/dcache_top.sv ====
`default_nettype none

module dcache_top #(
  parameter int SET_BITS = 4 // Index bits, 16 sets by default.
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             cpu_req,        // CPU request.
  input  cache_pkg::addr_t cpu_addr,       // CPU byte address.
  output logic             cpu_ack,        // CPU acknowledge.
  output cache_pkg::word_t cpu_data,       // Word returned to the CPU.
  output logic             mem_rd,         // Memory read request.
  output cache_pkg::addr_t mem_addr,       // Memory word address.
  input  cache_pkg::word_t mem_data,       // Memory read data.
  input  logic             mem_data_valid  // Memory data strobe.
);

  cache_pkg::addr_t lookup_addr;   // Address compared and read in the arrays.
  cache_pkg::addr_t miss_addr;     // Address handed to the fill machine.
  cache_pkg::word_t rd_data;       // Word read from the data array.
  logic             hit;           // Tag match.
  logic             miss_detected; // Fill request pulse.
  logic             fill_busy;     // Fill in progress.

  cache_fill_if fill_bus (); // Array write path.

  cache_access_ctrl u_access (
    .clk, .arst_n, .cpu_req, .cpu_addr, .cpu_ack, .cpu_data,
    .hit, .rd_data, .miss_detected, .miss_addr, .fill_busy, .lookup_addr
  );

  cache_fill_ctrl u_fill (
    .clk, .arst_n, .miss_detected, .miss_addr, .mem_data, .mem_data_valid,
    .fill_busy, .mem_rd, .mem_addr,
    .fill (fill_bus.ctrl)
  );

  cache_tag_array #(.SET_BITS(SET_BITS)) u_tags (
    .clk, .arst_n, .lookup_addr, .hit,
    .fill (fill_bus.array)
  );

  cache_data_array #(.SET_BITS(SET_BITS)) u_data (
    .clk,
    .rd_addr (lookup_addr),
    .rd_data,
    .fill    (fill_bus.array)
  );

endmodule

`default_nettype wire

// ==== dv/dcache_properties.sv ====
`default_nettype none

module dcache_properties (
  input logic             clk,
  input logic             arst_n,
  input logic             cpu_req,        // CPU request.
  input logic             cpu_ack,        // Cache acknowledge.
  input logic             mem_rd,         // Memory read request.
  input cache_pkg::addr_t mem_addr,       // Word address being fetched.
  input logic             mem_data_valid, // Memory return strobe.
  input logic             tag_we          // Tag write from the fill machine.
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0; // Number of failed assertions so far.

  ////////////////////////////////////////////////////////////
  // CPU four-phase handshake.
  ////////////////////////////////////////////////////////////
  ack_needs_req: assert property (
    @(posedge clk) disable iff (!arst_n) $rose(cpu_ack) |-> $past(cpu_req)
  ) else begin
    fail_count++;
    $error("cpu_ack rose while cpu_req was low");
  end

  ack_falls_after_req: assert property (
    @(posedge clk) disable iff (!arst_n) $fell(cpu_ack) |-> !$past(cpu_req)
  ) else begin
    fail_count++;
    $error("cpu_ack fell while cpu_req was still high");
  end

  ////////////////////////////////////////////////////////////
  // Fill side.
  ////////////////////////////////////////////////////////////
  addr_held_until_valid: assert property (
    @(posedge clk) disable iff (!arst_n) (mem_rd && !mem_data_valid) |=> $stable(mem_addr)
  ) else begin
    fail_count++;
    $error("mem_addr moved before its word was returned");
  end

  tag_we_one_cycle: assert property (
    @(posedge clk) disable iff (!arst_n) tag_we |=> !tag_we
  ) else begin
    fail_count++;
    $error("tag_we stayed high for more than one cycle");
  end

endmodule

// The tag write strobe is only visible on the internal fill bus.
bind dcache_top dcache_properties u_props (
  .clk, .arst_n, .cpu_req, .cpu_ack, .mem_rd, .mem_addr, .mem_data_valid,
  .tag_we (fill_bus.tag_we)
);

`default_nettype wire

// ==== dv/dcache_tb.sv ====
`default_nettype none

module dcache_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SET_BITS    = 4;   // Matches the DUT default.
  localparam int NUM_SETS    = 1 << SET_BITS;
  localparam int TAG_W       = cache_pkg::ADDR_W - cache_pkg::OFFSET_W - SET_BITS;
  localparam int NUM_XFERS   = 300; // CPU reads in the random run.
  localparam int WAIT_LIMIT  = 200; // Cycles allowed for any single wait.
  localparam logic [15:0] MEM_KEY = 16'h5a3c; // Memory word is address XOR this key.

  logic             clk;
  logic             arst_n;
  logic             cpu_req;
  cache_pkg::addr_t cpu_addr;
  logic             cpu_ack;
  cache_pkg::word_t cpu_data;
  logic             mem_rd;
  cache_pkg::addr_t mem_addr;
  cache_pkg::word_t mem_data;
  logic             mem_data_valid;

  logic [31:0]      lfsr_q = 32'hefe;  // Shared random state.
  cache_pkg::addr_t mem_reads [$];     // Addresses returned by memory in this transfer.
  logic             rd_seen;           // mem_rd was high during this transfer.
  logic             exp_valid [NUM_SETS]; // Reference model valid bits.
  logic [TAG_W-1:0] exp_tag [NUM_SETS];   // Reference model tags.

  dcache_top #(.SET_BITS(SET_BITS)) UUT (
    .clk, .arst_n, .cpu_req, .cpu_addr, .cpu_ack, .cpu_data,
    .mem_rd, .mem_addr, .mem_data, .mem_data_valid
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period.
  end

  ////////////////////////////////////////////////////////////
  // Helpers.
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1.
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q); // One step per bit taken.
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  function automatic cache_pkg::word_t mem_word(input cache_pkg::addr_t a);
    return a ^ MEM_KEY; // Every address holds a distinct, predictable word.
  endfunction

  function automatic logic [TAG_W-1:0] pool_tag(input logic [1:0] sel);
    case (sel)
      2'd0:    return TAG_W'(16'h0000);
      2'd1:    return TAG_W'(16'h003c);
      2'd2:    return TAG_W'(16'h00a5);
      default: return TAG_W'(16'h00ff);
    endcase
  endfunction

  task automatic fail_and_stop();
    $display("*** FAILED ***");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t ns: %s: got %0h, expected %0h", $time, what, got, exp);
      fail_and_stop();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Memory model with random return delay.
  ////////////////////////////////////////////////////////////
  initial begin : memory_model
    logic [31:0] dly;
    forever begin
      @(negedge clk);
      mem_data_valid = 1'b0; // Strobe lasts one cycle.
      if (arst_n && mem_rd) begin
        take_bits(3, dly);
        repeat (dly % 6) @(negedge clk); // Address is held while we stall.
        mem_data       = mem_word(mem_addr);
        mem_data_valid = 1'b1;
        mem_reads.push_back(mem_addr);
      end
    end
  end

  always @(negedge clk) begin
    if (mem_rd === 1'b1) rd_seen <= 1'b1; // Any fill activity at all.
  end

  // A failed bound assertion ends the run on the next falling edge.
  always @(negedge clk) begin
    if (UUT.u_props.fail_count != 0) begin
      $display("A bound assertion on the DUT failed.");
      fail_and_stop();
    end
  end

  ////////////////////////////////////////////////////////////
  // CPU stimulus and checks.
  ////////////////////////////////////////////////////////////
  initial begin : stimulus
    logic [31:0]      r;
    logic [TAG_W-1:0] tag;
    logic [SET_BITS-1:0] set_idx;
    logic [2:0]       word;
    logic             pred_hit;
    cache_pkg::addr_t addr;
    cache_pkg::addr_t base;
    int               cycles;
    int               n;
    int               i;
    cpu_req        = 1'b0;
    cpu_addr       = '0;
    mem_data       = '0;
    mem_data_valid = 1'b0;
    arst_n         = 1'b0;
    rd_seen        = 1'b0;
    for (i = 0; i < NUM_SETS; i++) exp_valid[i] = 1'b0; // Model starts empty too.
    repeat (8) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    check_eq(cpu_ack, 1'b0, "cpu_ack after reset");
    check_eq(mem_rd, 1'b0, "mem_rd after reset");

    for (n = 0; n < NUM_XFERS; n++) begin
      take_bits(2, r);
      tag = pool_tag(r[1:0]);
      take_bits(2, r);
      set_idx = SET_BITS'(r[1:0]); // Only four sets so that conflicts are frequent.
      take_bits(3, r);
      word     = r[2:0];
      addr     = {tag, set_idx, word, 1'b0};
      base     = {addr[15:4], 4'b0000};
      pred_hit = exp_valid[set_idx] && (exp_tag[set_idx] == tag);
      mem_reads.delete();
      rd_seen  = 1'b0;
      cpu_addr = addr;
      cpu_req  = 1'b1;
      cycles   = 0;
      while (cpu_ack !== 1'b1) begin
        @(negedge clk);
        cycles++;
        if (cycles > WAIT_LIMIT) begin
          $display("Timeout: no cpu_ack for the read of address %h.", addr);
          fail_and_stop();
        end
      end
      check_eq(cpu_data, mem_word(addr), "read data");
      if (pred_hit) begin
        check_eq(cycles, 2, "hit latency in cycles");
        check_eq(rd_seen, 1'b0, "mem_rd during a hit");
      end else begin
        check_eq(mem_reads.size(), 8, "memory reads for a miss");
        for (i = 0; i < 8; i++) begin
          check_eq(mem_reads[i], base + cache_pkg::addr_t'(2 * i), "fill read address");
        end
        exp_valid[set_idx] = 1'b1; // Block replaces whatever lived in the set.
        exp_tag[set_idx]   = tag;
      end
      cpu_req = 1'b0;
      cycles  = 0;
      while (cpu_ack !== 1'b0) begin
        @(negedge clk);
        cycles++;
        if (cycles > WAIT_LIMIT) begin
          $display("Timeout: cpu_ack stayed high after cpu_req fell.");
          fail_and_stop();
        end
      end
    end

    if (UUT.u_props.fail_count != 0) begin
      $display("%0d assertion failures were reported.", UUT.u_props.fail_count);
      fail_and_stop();
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== files.f ====
hw/cache_pkg.sv
hw/cache_fill_if.sv
hw/cache_fill_ctrl.sv
hw/cache_tag_array.sv
hw/cache_data_array.sv
hw/cache_access_ctrl.sv
hw/dcache_top.sv
dv/dcache_properties.sv
dv/dcache_tb.sv
